//--- angle_tracker.sv
`default_nettype none

module angle_tracker #(
   parameter int ROTATIONAL_RES = 8,
   parameter int HALL_MAX_BITS = 24,
   localparam int THETA_BITS = $clog2(ROTATIONAL_RES)
) (
   input wire clk_in,
   input wire rst_in,
   input wire hall_in,
   output logic sector_strobe,
   output logic [THETA_BITS-1:0] theta
);

   logic hall_meta;
   logic hall_sync;
   logic hall_prev;
   logic hall_edge;
   logic first_seen;                        // one hall edge seen so far
   logic [1:0] start_pipe;                  // edge to first strobe delay
   logic running;
   logic [HALL_MAX_BITS-1:0] rev_cnt;
   logic [HALL_MAX_BITS-1:0] rev_len;       // cycles of the last revolution
   logic [HALL_MAX_BITS-1:0] sector_len;
   logic [HALL_MAX_BITS-1:0] sec_timer;

   assign hall_edge = hall_sync & ~hall_prev;

   // revolution length and the derived sector length
   always_ff @(posedge clk_in) begin
      if (hall_edge) rev_len <= rev_cnt;
      if (start_pipe[0]) sector_len <= rev_len >> THETA_BITS;
   end

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         hall_meta <= 1'b0;
         hall_sync <= 1'b0;
         hall_prev <= 1'b0;
         first_seen <= 1'b0;
         start_pipe <= '0;
         rev_cnt <= '0;
         running <= 1'b0;
         sector_strobe <= 1'b0;
         theta <= '0;
         sec_timer <= '0;
      end else begin
         hall_meta <= hall_in;
         hall_sync <= hall_meta;
         hall_prev <= hall_sync;
         sector_strobe <= 1'b0;
         start_pipe <= {start_pipe[0], hall_edge & first_seen};

         if (hall_edge) begin
            first_seen <= 1'b1;
            rev_cnt <= HALL_MAX_BITS'(1);
         end else if (rev_cnt != '1) begin
            rev_cnt <= rev_cnt + 1'b1;  // saturates on a stalled rotor
         end

         if (start_pipe[1]) begin
            running <= 1'b1;
            sector_strobe <= 1'b1;
            theta <= '0;
            sec_timer <= '0;
         end else if (hall_edge) begin
            running <= 1'b0;  // new revolution, wait for the new length
         end else if (running) begin
            if (sec_timer + 1'b1 >= sector_len) begin
               sec_timer <= '0;
               if (theta == THETA_BITS'(ROTATIONAL_RES - 1)) begin
                  running <= 1'b0;  // all sectors done this turn
               end else begin
                  theta <= theta + 1'b1;
                  sector_strobe <= 1'b1;
               end
            end else begin
               sec_timer <= sec_timer + 1'b1;
            end
         end
      end
   end

   // sector 0 only ever comes from a hall edge, never from a wrapping count
   theta_no_wrap: assert property (@(posedge clk_in) disable iff (rst_in)
      (sector_strobe && theta == '0) |-> $past(start_pipe[1]))
      else $error("theta wrapped inside one revolution");

endmodule

`default_nettype wire

//--- column_fetch.sv
`default_nettype none

module column_fetch
   import hub75_pkg::*;
#(
   parameter int ROTATIONAL_RES = 8,
   parameter int NUM_COLS = 8,
   parameter int SCAN_RATE = 4,
   localparam int THETA_BITS = $clog2(ROTATIONAL_RES),
   localparam int ADDR_BITS = $clog2(SCAN_RATE),
   localparam int COL_BITS = $clog2(NUM_COLS),
   localparam int RD_BITS = THETA_BITS + 1 + ADDR_BITS + COL_BITS
) (
   input wire clk_in,
   input wire rst_in,
   input wire sector_strobe,
   input wire [THETA_BITS-1:0] theta,
   output logic rd_en,
   output logic [RD_BITS-1:0] rd_addr,
   input wire pixel_t rd_pixel,
   output pixel_t [1:0][NUM_COLS-1:0] column_data,
   output logic [ADDR_BITS-1:0] address_data,
   output logic tvalid,
   input wire tready,
   output logic sector_missed
);

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_READ = 2'd1;
   localparam logic [1:0] S_OFFER = 2'd2;

   logic [1:0] state;
   logic [THETA_BITS-1:0] sector;
   logic [COL_BITS:0] rd_cnt;   // msb picks the panel half
   logic [COL_BITS:0] wb_cnt;   // trails rd_cnt by the read latency
   logic wb_valid;

   assign rd_en = state == S_READ;
   // row h*SCAN_RATE+a of the image lands in half h
   assign rd_addr = {sector, rd_cnt[COL_BITS], address_data, rd_cnt[COL_BITS-1:0]};
   assign tvalid = (state == S_OFFER) && !wb_valid;  // last word written back

   // write-back of the word read one cycle earlier
   always_ff @(posedge clk_in) begin
      wb_cnt <= rd_cnt;
      if (wb_valid) begin
         column_data[wb_cnt[COL_BITS]][wb_cnt[COL_BITS-1:0]].raw <= rd_pixel.raw;
      end
   end

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         state <= S_IDLE;
         sector <= '0;
         rd_cnt <= '0;
         wb_valid <= 1'b0;
         address_data <= '0;
         sector_missed <= 1'b0;
      end else begin
         wb_valid <= rd_en;

         // sweep still busy, this sector is lost
         if (sector_strobe && state != S_IDLE) begin
            sector_missed <= 1'b1;
         end

         case (state)
            S_IDLE: begin
               if (sector_strobe) begin
                  sector <= theta;
                  address_data <= '0;
                  rd_cnt <= '0;
                  state <= S_READ;
               end
            end
            S_READ: begin
               rd_cnt <= rd_cnt + 1'b1;
               if (rd_cnt == (COL_BITS + 1)'(2 * NUM_COLS - 1)) begin
                  state <= S_OFFER;
               end
            end
            S_OFFER: begin
               if (tvalid && tready) begin
                  if (address_data == ADDR_BITS'(SCAN_RATE - 1)) begin
                     state <= S_IDLE;  // sector finished
                  end else begin
                     address_data <= address_data + 1'b1;
                     rd_cnt <= '0;
                     state <= S_READ;
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // offered line must not move until the driver takes it
   line_held: assert property (@(posedge clk_in) disable iff (rst_in)
      (tvalid && !tready) |=> (tvalid && $stable(column_data) && $stable(address_data)))
      else $error("column_data changed while waiting for tready");

endmodule

`default_nettype wire

//--- compile.f
hub75_pkg.sv
angle_tracker.sv
frame_buffer.sv
column_fetch.sv
hub75_output.sv
pov_display_top.sv
tb_clock_gen.sv
pov_display_tb.sv

//--- frame_buffer.sv
`default_nettype none

module frame_buffer
   import hub75_pkg::*;
#(
   parameter int ROTATIONAL_RES = 8,
   parameter int NUM_COLS = 8,
   parameter int SCAN_RATE = 4,
   localparam int ADDR_BITS = $clog2(ROTATIONAL_RES) + $clog2(2 * SCAN_RATE)
                              + $clog2(NUM_COLS),
   localparam int DEPTH = ROTATIONAL_RES * 2 * SCAN_RATE * NUM_COLS
) (
   input wire clk_in,
   input wire wr_en,
   input wire [ADDR_BITS-1:0] wr_addr,     // {sector, row, column}
   input wire pixel_t wr_pixel,
   input wire rd_en,
   input wire [ADDR_BITS-1:0] rd_addr,
   output pixel_t rd_pixel
);

   // one word per pixel of every sector image
   logic [RGB_RES-1:0] mem [DEPTH];

   // host side, one pixel per cycle
   always_ff @(posedge clk_in) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_pixel.raw;
      end
   end

   // fetch side, data one cycle after rd_en
   always_ff @(posedge clk_in) begin
      if (rd_en) begin
         rd_pixel.raw <= mem[rd_addr];
      end
   end

endmodule

`default_nettype wire

//--- hub75_output.sv
`default_nettype none

module hub75_output
   import hub75_pkg::*;
#(
   parameter int NUM_COLS = 64,
   parameter int SCAN_RATE = 32,
   parameter int PERIOD = 1,        // hold cycles of plane 0
   localparam int ADDR_BITS = $clog2(SCAN_RATE),
   localparam int PIX_BITS = $clog2(NUM_COLS),
   localparam int HOLD_BITS = $clog2(PERIOD << (PLANES - 1)) + 1
) (
   input wire rst_in,
   input wire clk_in,
   input wire pixel_t [1:0][NUM_COLS-1:0] column_data,
   input wire [ADDR_BITS-1:0] address_data,

   output logic [2:0] rgb0,
   output logic [2:0] rgb1,

   output logic led_latch,
   output logic led_clk,
   output logic led_output_enable,  // active low
   output logic [ADDR_BITS-1:0] hub75_address,

   // line handshake from the fetcher
   input wire tvalid,
   output logic tready
);

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_SHIFT = 2'd1;
   localparam logic [1:0] S_HOLD = 2'd2;

   logic [1:0] state;
   logic [PIX_BITS-1:0] pixel_counter;
   logic [PLANE_BITS-1:0] plane;
   logic [HOLD_BITS-1:0] hold_cnt;
   logic [HOLD_BITS-1:0] hold_len;
   logic clk_msk;
   pixel_t [1:0][NUM_COLS-1:0] columns;
   pixel_t top_px;
   pixel_t bot_px;

   // panel clock only in the low half, data settles on the rising edge
   assign led_clk = ~clk_in & clk_msk;
   assign tready = state == S_IDLE;
   assign hold_len = HOLD_BITS'(PERIOD) << plane;  // binary plane weight

   assign top_px = columns[0][pixel_counter];
   assign bot_px = columns[1][pixel_counter];

   // bit p of each color for plane p
   assign rgb0 = {top_px.fields.blue[plane], top_px.fields.green[plane],
                  top_px.fields.red[plane]};
   assign rgb1 = {bot_px.fields.blue[plane], bot_px.fields.green[plane],
                  bot_px.fields.red[plane]};

   always_ff @(posedge clk_in) begin
      if (tvalid && tready) columns <= column_data;
   end

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         state <= S_IDLE;
         pixel_counter <= '0;
         plane <= '0;
         hold_cnt <= '0;
         clk_msk <= 1'b0;
         led_latch <= 1'b0;
         led_output_enable <= 1'b1;
         hub75_address <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (tvalid) begin
                  state <= S_SHIFT;
                  clk_msk <= 1'b1;
                  pixel_counter <= '0;
                  plane <= '0;
                  hub75_address <= address_data;
               end
            end
            S_SHIFT: begin
               if (pixel_counter == PIX_BITS'(NUM_COLS - 1)) begin
                  state <= S_HOLD;
                  clk_msk <= 1'b0;
                  led_latch <= 1'b1;
                  led_output_enable <= 1'b0;  // show from the latch cycle on
                  hold_cnt <= '0;
               end else begin
                  pixel_counter <= pixel_counter + 1'b1;
               end
            end
            S_HOLD: begin
               led_latch <= 1'b0;
               if (hold_cnt == hold_len - 1'b1) begin
                  led_output_enable <= 1'b1;
                  hold_cnt <= '0;
                  if (plane == PLANE_BITS'(PLANES - 1)) begin
                     state <= S_IDLE;
                  end else begin
                     plane <= plane + 1'b1;  // next weight
                     pixel_counter <= '0;
                     clk_msk <= 1'b1;
                     state <= S_SHIFT;
                  end
               end else begin
                  hold_cnt <= hold_cnt + 1'b1;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // latch is a lone pulse, with the panel clock stopped
   latch_no_clk: assert property (@(posedge clk_in) disable iff (rst_in)
      led_latch |-> !clk_msk ##1 !led_latch)
      else $error("led_latch overlaps led_clk activity");

endmodule

`default_nettype wire

//--- hub75_pkg.sv
`default_nettype none

package hub75_pkg;

   // pixel format, RGB333
   localparam int RGB_RES = 9;

   // one bit plane per color bit
   localparam int PLANES = 3;

   localparam int COLOR_BITS = RGB_RES / 3;  // bits per color channel

   // width of a plane index
   localparam int PLANE_BITS = $clog2(PLANES);

   // one pixel word, either as a whole or per color.
   // blue sits in the top bits, red in the bottom
   typedef union packed {
      logic [RGB_RES-1:0] raw;  // as stored in the frame buffer
      struct packed {
         logic [COLOR_BITS-1:0] blue;
         logic [COLOR_BITS-1:0] green;
         logic [COLOR_BITS-1:0] red;
      } fields;  // per-channel view for plane selection
   } pixel_t;

endpackage

`default_nettype wire

//--- pov_display_tb.sv
`default_nettype none

module pov_display_tb;

   localparam int RES = 8;
   localparam int COLS = 8;
   localparam int SCAN = 4;
   localparam int PER = 2;
   localparam int PLANES = 3;
   localparam int SEED = 36748;
   localparam int HALL_WIDTH = 4;          // hall pulse length in cycles
   localparam int DONE_TIMEOUT = 4000;
   localparam int ENTRIES = 3;

   // hall period in cycles, and the sector_missed value expected after it
   int hall_period [ENTRIES] = '{1760, 2400, 400};
   bit missed_exp [ENTRIES] = '{1'b0, 1'b0, 1'b1};

   logic clk_in;
   logic rst_in;
   logic hall_in;
   logic wr_en;
   logic [2:0] wr_sector;
   logic [2:0] wr_row;
   logic [2:0] wr_col;
   logic [8:0] wr_pixel;
   logic [2:0] rgb0;
   logic [2:0] rgb1;
   logic led_clk;
   logic led_latch;
   logic led_output_enable;
   logic [1:0] hub75_address;
   logic sector_missed;

   logic [8:0] ref_img [RES][2 * SCAN][COLS];  // {blue, green, red}
   logic [2:0] top_smp [COLS];
   logic [2:0] bot_smp [COLS];
   int clk_total = 0;       // led_clk pulses since reset
   int clk_at_latch = 0;
   int latch_cnt = 0;
   int holds_done = 0;
   int low_run = 0;         // current run of blanking-off cycles
   int hold_exp = 0;
   bit check_data = 1'b1;
   int error_count = 0;

   tb_clock_gen #(.CLK_PERIOD(20)) clk_gen_i (.clk(clk_in));

   pov_display_top #(
      .ROTATIONAL_RES(RES),
      .NUM_COLS(COLS),
      .SCAN_RATE(SCAN),
      .PERIOD(PER),
      .HALL_MAX_BITS(16)
   ) dut_i (
      .clk_in(clk_in),
      .rst_in(rst_in),
      .hall_in(hall_in),
      .wr_en(wr_en),
      .wr_sector(wr_sector),
      .wr_row(wr_row),
      .wr_col(wr_col),
      .wr_pixel(wr_pixel),
      .rgb0(rgb0),
      .rgb1(rgb1),
      .led_clk(led_clk),
      .led_latch(led_latch),
      .led_output_enable(led_output_enable),
      .hub75_address(hub75_address),
      .sector_missed(sector_missed)
   );

   task automatic report_mismatch(input string name, input int expected, input int actual);
      error_count++;
      $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic abort_run(input string what);
      error_count++;
      $display("%s at t=%0t", what, $time);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first error");
   endtask

   // pins carry bit p of blue, green and red
   function automatic logic [2:0] plane_slice(input logic [8:0] px, input int p);
      plane_slice = {px[6 + p], px[3 + p], px[p]};
   endfunction

   // one random pixel per write, sector by sector
   task automatic load_image();
      for (int s = 0; s < RES; s++) begin
         for (int r = 0; r < 2 * SCAN; r++) begin
            for (int c = 0; c < COLS; c++) begin
               @(negedge clk_in);
               ref_img[s][r][c] = 9'($urandom());
               wr_en = 1'b1;
               wr_sector = 3'(s);
               wr_row = 3'(r);
               wr_col = 3'(c);
               wr_pixel = ref_img[s][r][c];
            end
         end
      end
      @(negedge clk_in);
      wr_en = 1'b0;
   endtask

   task automatic drive_revolution(input int period, input bit idle_check);
      for (int i = 0; i < period; i++) begin
         @(negedge clk_in);
         hall_in = (i < HALL_WIDTH);
         if (idle_check) begin
            assert (led_latch == 1'b0)
               else report_mismatch("led_latch", 0, int'(led_latch));
            assert (led_output_enable == 1'b1)
               else report_mismatch("led_output_enable", 1, int'(led_output_enable));
         end
      end
   endtask

   // until every latched plane has finished its hold
   task automatic wait_display_done(input int target);
      int cycles;
      cycles = 0;
      while (holds_done < target) begin
         @(posedge clk_in);
         cycles++;
         if (cycles > DONE_TIMEOUT) abort_run("timeout waiting for the display to finish");
      end
      assert (latch_cnt == target) else report_mismatch("latch count", target, latch_cnt);
   endtask

   task automatic check_latch();
      int plane;
      int line;
      int addr;
      int sector;
      plane = latch_cnt % PLANES;
      line = latch_cnt / PLANES;
      addr = line % SCAN;
      sector = (line / SCAN) % RES;  // 8 sectors per turn, in strobe order
      assert (low_run == 1) else abort_run("led_output_enable did not fall with led_latch");
      assert (clk_total - clk_at_latch == COLS)
         else report_mismatch("led_clk pulses", COLS, clk_total - clk_at_latch);
      assert (hub75_address == 2'(addr))
         else report_mismatch("hub75_address", addr, int'(hub75_address));
      if (check_data) begin
         for (int c = 0; c < COLS; c++) begin
            assert (top_smp[c] == plane_slice(ref_img[sector][addr][c], plane))
               else report_mismatch($sformatf("rgb0 col %0d", c),
                  int'(plane_slice(ref_img[sector][addr][c], plane)), int'(top_smp[c]));
            assert (bot_smp[c] == plane_slice(ref_img[sector][SCAN + addr][c], plane))
               else report_mismatch($sformatf("rgb1 col %0d", c),
                  int'(plane_slice(ref_img[sector][SCAN + addr][c], plane)), int'(bot_smp[c]));
         end
      end
      hold_exp = PER << plane;  // binary weight
      clk_at_latch = clk_total;
      latch_cnt++;
   endtask

   // panel samples data on its own clock
   always @(posedge led_clk) begin
      if (!rst_in) begin
         if (clk_total - clk_at_latch < COLS) begin
            top_smp[clk_total - clk_at_latch] = rgb0;
            bot_smp[clk_total - clk_at_latch] = rgb1;
         end
         clk_total++;
      end
   end

   always @(negedge clk_in) begin
      if (!rst_in) begin
         if (!led_output_enable) begin
            low_run++;
         end else if (low_run != 0) begin
            assert (low_run == hold_exp)
               else report_mismatch("led_output_enable low cycles", hold_exp, low_run);
            low_run = 0;
            holds_done++;
         end
         if (led_latch) check_latch();
      end
   end

   initial begin
      int shown;
      shown = 0;
      rst_in = 1'b1;
      hall_in = 1'b0;
      wr_en = 1'b0;
      wr_sector = '0;
      wr_row = '0;
      wr_col = '0;
      wr_pixel = '0;
      void'($urandom(SEED));
      repeat (4) @(negedge clk_in);
      rst_in = 1'b0;
      @(negedge clk_in);
      assert (led_latch == 1'b0) else report_mismatch("led_latch", 0, int'(led_latch));
      assert (led_output_enable == 1'b1)
         else report_mismatch("led_output_enable", 1, int'(led_output_enable));
      assert (sector_missed == 1'b0)
         else report_mismatch("sector_missed", 0, int'(sector_missed));
      load_image();
      // first hall pulse only arms the tracker
      drive_revolution(hall_period[0], 1'b1);
      assert (clk_total == 0) else report_mismatch("led_clk pulses", 0, clk_total);

      for (int e = 0; e < ENTRIES; e++) begin
         if (missed_exp[e]) check_data = 1'b0;  // dropped sectors, shown order unknown
         drive_revolution(hall_period[e], 1'b0);
         drive_revolution(hall_period[e], 1'b0);
         if (!missed_exp[e]) begin
            shown += 2 * RES * SCAN * PLANES;
            wait_display_done(shown);
         end
         @(negedge clk_in);
         assert (sector_missed == missed_exp[e])
            else report_mismatch("sector_missed", int'(missed_exp[e]), int'(sector_missed));
      end

      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- pov_display_top.sv
`default_nettype none

module pov_display_top
   import hub75_pkg::*;
#(
   parameter int ROTATIONAL_RES = 128,
   parameter int NUM_COLS = 64,
   parameter int SCAN_RATE = 32,
   parameter int PERIOD = 1,
   parameter int HALL_MAX_BITS = 24,
   localparam int THETA_BITS = $clog2(ROTATIONAL_RES),
   localparam int ROW_BITS = $clog2(2 * SCAN_RATE),
   localparam int COL_BITS = $clog2(NUM_COLS),
   localparam int ADDR_BITS = $clog2(SCAN_RATE),
   localparam int FB_BITS = THETA_BITS + ROW_BITS + COL_BITS
) (
   input wire clk_in,
   input wire rst_in,
   input wire hall_in,

   // host pixel writes
   input wire wr_en,
   input wire [THETA_BITS-1:0] wr_sector,
   input wire [ROW_BITS-1:0] wr_row,
   input wire [COL_BITS-1:0] wr_col,
   input wire pixel_t wr_pixel,

   // panel pins
   output logic [2:0] rgb0,
   output logic [2:0] rgb1,
   output logic led_clk,
   output logic led_latch,
   output logic led_output_enable,
   output logic [ADDR_BITS-1:0] hub75_address,

   output logic sector_missed
);

   logic sector_strobe;
   logic [THETA_BITS-1:0] theta;
   logic [FB_BITS-1:0] wr_addr;
   logic rd_en;
   logic [FB_BITS-1:0] rd_addr;
   pixel_t rd_pixel;
   pixel_t [1:0][NUM_COLS-1:0] column_data;
   logic [ADDR_BITS-1:0] address_data;
   logic tvalid;
   logic tready;

   assign wr_addr = {wr_sector, wr_row, wr_col};

   angle_tracker #(
      .ROTATIONAL_RES(ROTATIONAL_RES),
      .HALL_MAX_BITS(HALL_MAX_BITS)
   ) angle_i (
      .clk_in(clk_in),
      .rst_in(rst_in),
      .hall_in(hall_in),
      .sector_strobe(sector_strobe),
      .theta(theta)
   );

   frame_buffer #(
      .ROTATIONAL_RES(ROTATIONAL_RES),
      .NUM_COLS(NUM_COLS),
      .SCAN_RATE(SCAN_RATE)
   ) fb_i (
      .clk_in(clk_in),
      .wr_en(wr_en),
      .wr_addr(wr_addr),
      .wr_pixel(wr_pixel),
      .rd_en(rd_en),
      .rd_addr(rd_addr),
      .rd_pixel(rd_pixel)
   );

   column_fetch #(
      .ROTATIONAL_RES(ROTATIONAL_RES),
      .NUM_COLS(NUM_COLS),
      .SCAN_RATE(SCAN_RATE)
   ) fetch_i (
      .clk_in(clk_in),
      .rst_in(rst_in),
      .sector_strobe(sector_strobe),
      .theta(theta),
      .rd_en(rd_en),
      .rd_addr(rd_addr),
      .rd_pixel(rd_pixel),
      .column_data(column_data),
      .address_data(address_data),
      .tvalid(tvalid),
      .tready(tready),
      .sector_missed(sector_missed)
   );

   hub75_output #(
      .NUM_COLS(NUM_COLS),
      .SCAN_RATE(SCAN_RATE),
      .PERIOD(PERIOD)
   ) out_i (
      .rst_in(rst_in),
      .clk_in(clk_in),
      .column_data(column_data),
      .address_data(address_data),
      .rgb0(rgb0),
      .rgb1(rgb1),
      .led_latch(led_latch),
      .led_clk(led_clk),
      .led_output_enable(led_output_enable),
      .hub75_address(hub75_address),
      .tvalid(tvalid),
      .tready(tready)
   );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pov_display_tb -f compile.f -o pov_sim

./obj_dir/pov_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
   parameter int CLK_PERIOD = 20
) (
   output logic clk
);

   // free running, starts low
   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2);
         clk = ~clk;
      end
   end

endmodule

`default_nettype wire
